// ==== Makefile ====
# Verilator build and run for the instruction cache lookup testbench

TOP := tb_icache_lookup

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -Wno-fatal -f sources.f \
		--top-module $(TOP) -Mdir obj_dir -o V$(TOP)

# The log decides pass or fail
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	grep -qx ">>> PASS" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/tb_icache_lookup.sv ====
/*
 * Testbench for the instruction cache lookup
 * Reference model of tags and lines, random stimulus, in-order checker and watchdog
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module tb_icache_lookup import icache_pkg::*; ();

  localparam logic [31:0] Seed           = 32'h363d;
  localparam int unsigned NumTxn         = 120;
  localparam int unsigned WatchdogCycles = NumTxn * 40;

  // Expected response of one lookup
  typedef struct packed {
    addr_t    addr;
    id_t      id;
    logic     hit;
    set_idx_t way;
    logic     error;
    line_t    data;
  } rsp_t;

  logic      clk_i, rst_ni, flush_valid_i;
  addr_t     in_addr_i;
  id_t       in_id_i;
  logic      in_valid_i, in_ready_o;
  addr_t     out_addr_o;
  id_t       out_id_o;
  set_idx_t  out_set_o;
  logic      out_hit_o, out_error_o, out_valid_o, out_ready_i;
  line_t     out_data_o;
  line_idx_t write_index_i;
  set_idx_t  write_set_i;
  tag_t      write_tag_i;
  logic      write_error_i, write_valid_i, write_ready_o;
  line_t     write_data_i;

  // Model of the cache contents
  logic  model_valid [`ICACHE_SET_COUNT][`ICACHE_LINE_COUNT];
  logic  model_err   [`ICACHE_SET_COUNT][`ICACHE_LINE_COUNT];
  tag_t  model_tag   [`ICACHE_SET_COUNT][`ICACHE_LINE_COUNT];
  line_t model_line  [`ICACHE_SET_COUNT][`ICACHE_LINE_COUNT];

  rsp_t        expected_q [$];
  addr_t       pool_q [$];
  logic [31:0] rand_state, stall_state;
  logic        stall_on;
  int unsigned issued, received, checks;

  icache_lookup icache_lookup_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] next_random();
    rand_state = lcg_step(rand_state);
    return rand_state;
  endfunction

  function automatic addr_t make_addr(input tag_t tag, input line_idx_t idx);
    logic [`ICACHE_LINE_ALIGN-1:0] off;
    off = next_random() >> 20;
    return {tag, idx, off};
  endfunction

  // Lowest valid set with a matching tag wins
  function automatic rsp_t reference(input addr_t addr, input id_t id);
    rsp_t      r;
    line_idx_t idx;
    tag_t      tag;
    logic      found;
    r      = '0;
    r.addr = addr;
    r.id   = id;
    idx    = addr[`ICACHE_LINE_ALIGN +: `ICACHE_COUNT_ALIGN];
    tag    = addr[`ICACHE_FETCH_AW-1 -: `ICACHE_TAG_WIDTH];
    found  = 1'b0;
    for (int s = 0; s < `ICACHE_SET_COUNT; s++) begin
      if (!found && model_valid[s][idx] && model_tag[s][idx] == tag) begin
        r.hit   = 1'b1;
        r.way   = set_idx_t'(s);
        r.error = model_err[s][idx];
        r.data  = model_line[s][idx];
        found   = 1'b1;
      end
    end
    return r;
  endfunction

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      $display("FAILED at %0t ns: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
      $display(">>> FAIL");
      $fatal(1, "Value mismatch");
    end else begin
      checks++;
    end
  endtask

  task automatic clear_model();
    for (int s = 0; s < `ICACHE_SET_COUNT; s++) begin
      for (int i = 0; i < `ICACHE_LINE_COUNT; i++) begin
        model_valid[s][i] = 1'b0;
      end
    end
  endtask

  // Both ready outputs stay low for one cycle per line index
  task automatic wait_clear();
    for (int i = 0; i < `ICACHE_LINE_COUNT; i++) begin
      check_value(in_ready_o, 1'b0, "in_ready_o while clearing");
      check_value(write_ready_o, 1'b0, "write_ready_o while clearing");
      @(posedge clk_i);
      #1;
    end
    check_value(in_ready_o, 1'b1, "in_ready_o after clearing");
    check_value(write_ready_o, 1'b1, "write_ready_o after clearing");
  endtask

  task automatic wait_idle();
    while (expected_q.size() != 0) begin
      @(posedge clk_i);
    end
    #1;
  endtask

  task automatic issue_lookup(input addr_t addr);
    logic accepted;
    id_t  id;
    id         = id_t'(next_random() >> 24);
    in_addr_i  = addr;
    in_id_i    = id;
    in_valid_i = 1'b1;
    accepted   = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = in_ready_o;
      @(posedge clk_i);
      #1;
    end
    in_valid_i = 1'b0;
    expected_q.push_back(reference(addr, id));
    issued++;
  endtask

  task automatic refill_line(input line_idx_t idx, input set_idx_t way, input tag_t tag,
                             input logic err, input line_t data);
    logic accepted;
    wait_idle();
    write_index_i = idx;
    write_set_i   = way;
    write_tag_i   = tag;
    write_error_i = err;
    write_data_i  = data;
    write_valid_i = 1'b1;
    accepted      = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      accepted = write_ready_o;
      check_value(in_ready_o, 1'b0, "in_ready_o during refill");
      @(posedge clk_i);
      #1;
    end
    write_valid_i         = 1'b0;
    model_valid[way][idx] = 1'b1;
    model_err[way][idx]   = err;
    model_tag[way][idx]   = tag;
    model_line[way][idx]  = data;
    pool_q.push_back(make_addr(tag, idx));
  endtask

  // --------------------------------------------------
  // Output side
  // --------------------------------------------------
  // Random back-pressure driven just after the edge
  initial begin
    forever begin
      @(posedge clk_i);
      #1;
      stall_state = lcg_step(stall_state);
      out_ready_i = stall_on ? (stall_state[31:30] != 2'b00) : 1'b1;
    end
  end

  initial begin
    rsp_t head;
    forever begin
      @(negedge clk_i);
      if (rst_ni && out_valid_o && out_ready_i) begin
        if (expected_q.size() == 0) begin
          $display("An output transfer at %0t ns had no lookup outstanding", $time);
          $display(">>> FAIL");
          $fatal(1, "Extra transfer");
        end else begin
          head = expected_q.pop_front();
          received++;
          check_value(out_addr_o, head.addr, "out_addr_o");
          check_value(out_id_o, head.id, "out_id_o");
          check_value(out_hit_o, head.hit, "out_hit_o");
          if (head.hit) begin
            check_value(out_set_o, head.way, "out_set_o");
            check_value(out_error_o, head.error, "out_error_o");
            check_value(out_data_o, head.data, "out_data_o");
          end
        end
      end
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk_i);
    $display("The run did not finish within %0d cycles", WatchdogCycles);
    $display(">>> FAIL");
    $fatal(1, "Watchdog timeout");
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  initial begin
    tag_t      tag;
    line_idx_t idx;
    rst_ni        = 1'b0;
    flush_valid_i = 1'b0;
    in_addr_i     = '0;
    in_id_i       = '0;
    in_valid_i    = 1'b0;
    out_ready_i   = 1'b1;
    write_index_i = '0;
    write_set_i   = '0;
    write_tag_i   = '0;
    write_error_i = 1'b0;
    write_data_i  = '0;
    write_valid_i = 1'b0;
    stall_on      = 1'b0;
    rand_state    = Seed;
    stall_state   = lcg_step(Seed);
    issued        = 0;
    received      = 0;
    checks        = 0;
    clear_model();

    repeat (3) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
    wait_clear();

    // Everything misses in an empty cache
    repeat (20) issue_lookup(addr_t'(next_random()));

    // Refill then look up the same line
    for (int n = 0; n < 8; n++) begin
      refill_line(line_idx_t'(next_random() >> 8), set_idx_t'(next_random() >> 31),
                  tag_t'(next_random()), next_random() >> 31,
                  {next_random(), next_random()});
      issue_lookup(pool_q[pool_q.size() - 1]);
    end

    // Same tag in both sets of one index
    tag = tag_t'(next_random());
    idx = 4'd5;
    refill_line(idx, 1'b1, tag, 1'b1, {next_random(), next_random()});
    refill_line(idx, 1'b0, tag, 1'b0, {next_random(), next_random()});
    issue_lookup(make_addr(tag, idx));

    // Different tags, one per set
    idx = 4'd9;
    refill_line(idx, 1'b0, tag_t'(next_random()), 1'b0, {next_random(), next_random()});
    refill_line(idx, 1'b1, tag_t'(next_random()), 1'b1, {next_random(), next_random()});
    issue_lookup(pool_q[pool_q.size() - 2]);
    issue_lookup(pool_q[pool_q.size() - 1]);
    wait_idle();

    // Mixed stream under back-pressure
    stall_on = 1'b1;
    for (int n = 0; n < 60; n++) begin
      if (next_random() >> 31) begin
        issue_lookup(pool_q[(next_random() >> 8) % pool_q.size()]);
      end else begin
        issue_lookup(addr_t'(next_random()));
      end
    end
    wait_idle();
    stall_on = 1'b0;

    // Flush drops every refilled line
    flush_valid_i = 1'b1;
    @(posedge clk_i);
    #1;
    flush_valid_i = 1'b0;
    clear_model();
    wait_clear();
    foreach (pool_q[i]) issue_lookup(pool_q[i]);
    wait_idle();

    $display("%0d lookups issued, %0d returned, %0d checks", issued, received, checks);
    // Nothing may come out once every lookup has been answered
    if (!out_valid_o) begin
      $display(">>> PASS");
      $finish;
    end else begin
      $display("A response was still presented after the last lookup was answered");
      $display(">>> FAIL");
      $fatal(1, "Extra response");
    end
  end

endmodule

`default_nettype wire

// ==== hdl/icache_data_stage.sv ====
/*
 * Data stage
 * Reads the hitting line and presents the lookup result on the output channel
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_data_stage import icache_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,

  input  wire logic  clear_i,
  input  wire logic  tag_valid_i,
  input  addr_t      tag_addr_i,
  input  id_t        tag_id_i,
  input  wire logic  tag_hit_i,
  input  set_idx_t   tag_set_i,
  input  wire logic  tag_error_i,
  output logic       tag_ready_o,

  input  line_idx_t  write_index_i,
  input  set_idx_t   write_set_i,
  input  line_t      write_data_i,
  input  wire logic  write_valid_i,

  output addr_t      out_addr_o,
  output id_t        out_id_o,
  output set_idx_t   out_set_o,
  output logic       out_hit_o,
  output logic       out_error_o,
  output line_t      out_data_o,
  output logic       out_valid_o,
  input  wire logic  out_ready_i
);

  localparam int unsigned DataAddrWidth = `ICACHE_SET_ALIGN + `ICACHE_COUNT_ALIGN;

  typedef struct packed {
    addr_t    addr;
    id_t      id;
    set_idx_t cset;
    logic     hit;
    logic     error;
  } meta_t;

  line_t                    mem_q [`ICACHE_SET_COUNT * `ICACHE_LINE_COUNT];
  logic [DataAddrWidth-1:0] lookup_addr, write_addr;
  logic                     data_write, data_read;
  logic                     tag_hs;
  logic                     data_valid_q, rd_hs_q;
  line_t                    rdata_q, rsp_q;
  meta_t                    meta_q;

  assign lookup_addr = {tag_set_i, tag_addr_i[`ICACHE_LINE_ALIGN +: `ICACHE_COUNT_ALIGN]};
  assign write_addr  = {write_set_i, write_index_i};

  // --------------------------------------------------
  // Line memory port
  // --------------------------------------------------
  // Refill owns the port, the tag side waits
  assign data_write  = !clear_i && write_valid_i;
  assign tag_ready_o = (!data_valid_q || out_ready_i) && !data_write;
  assign tag_hs      = tag_valid_i && tag_ready_o;
  // Misses skip the read
  assign data_read   = tag_hs && tag_hit_i;

  always_ff @(posedge clk_i) begin
    if (data_write) begin
      mem_q[write_addr] <= write_data_i;
    end else if (data_read) begin
      rdata_q <= mem_q[lookup_addr];
    end
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      data_valid_q <= 1'b0;
      rd_hs_q      <= 1'b0;
    end else begin
      rd_hs_q <= data_read;
      if (tag_hs) begin
        data_valid_q <= 1'b1;
      end else if (out_ready_i) begin
        data_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (tag_hs) begin
      meta_q <= '{addr: tag_addr_i, id: tag_id_i, cset: tag_set_i,
                  hit: tag_hit_i, error: tag_error_i};
    end
  end

  // Keep the fresh line if the consumer stalls in the cycle it arrives
  always_ff @(posedge clk_i) begin
    if (rd_hs_q && !out_ready_i) begin
      rsp_q <= rdata_q;
    end
  end

  assign out_data_o  = rd_hs_q ? rdata_q : rsp_q;
  assign out_addr_o  = meta_q.addr;
  assign out_id_o    = meta_q.id;
  assign out_set_o   = meta_q.cset;
  assign out_hit_o   = meta_q.hit;
  assign out_error_o = meta_q.error;
  assign out_valid_o = data_valid_q;

  // Held response stays put until the consumer takes it
  a_out_stable : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_addr_o))
  );

endmodule

`default_nettype wire

// ==== hdl/icache_init_ctrl.sv ====
/*
 * Init and flush sequencer
 * Walks every line index once after reset or flush so the tags get cleared
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_init_ctrl import icache_pkg::*; (
  input  wire logic      clk_i,
  input  wire logic      rst_ni,
  input  wire logic      flush_valid_i,
  output logic           clear_o,
  output line_idx_t      clear_index_o
);

  localparam int unsigned CntWidth = `ICACHE_COUNT_ALIGN + 1;

  init_state_e         state_q, state_d;
  logic [CntWidth-1:0] count_q, count_d;

  always_comb begin
    state_d = state_q;
    count_d = count_q;
    unique case (state_q)
      INIT_CLEAR: begin
        count_d = count_q + 1'b1;
        // Last index written this cycle
        if (count_d == CntWidth'(`ICACHE_LINE_COUNT)) begin
          state_d = INIT_DONE;
        end
      end
      INIT_DONE: begin
        if (flush_valid_i) begin
          count_d = '0;
          state_d = INIT_CLEAR;
        end
      end
      default: begin
        state_d = INIT_CLEAR;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= INIT_CLEAR;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      count_q <= count_d;
    end
  end

  assign clear_o       = (state_q == INIT_CLEAR);
  assign clear_index_o = count_q[`ICACHE_COUNT_ALIGN-1:0];

  // A clear run only ends after the last line index
  a_clear_walks_all : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(clear_o) |-> ($past(clear_index_o) == line_idx_t'(`ICACHE_LINE_COUNT - 1))
  );

endmodule

`default_nettype wire

// ==== hdl/icache_lookup.sv ====
/*
 * Instruction cache lookup
 * Two-stage set-associative tag and data lookup with refill and flush
 */
`timescale 1ns/1ps
`default_nettype none

module icache_lookup import icache_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  input  wire logic  flush_valid_i,

  input  addr_t      in_addr_i,
  input  id_t        in_id_i,
  input  wire logic  in_valid_i,
  output logic       in_ready_o,

  output addr_t      out_addr_o,
  output id_t        out_id_o,
  output set_idx_t   out_set_o,
  output logic       out_hit_o,
  output logic       out_error_o,
  output line_t      out_data_o,
  output logic       out_valid_o,
  input  wire logic  out_ready_i,

  input  line_idx_t  write_index_i,
  input  set_idx_t   write_set_i,
  input  tag_t       write_tag_i,
  input  wire logic  write_error_i,
  input  line_t      write_data_i,
  input  wire logic  write_valid_i,
  output logic       write_ready_o
);

  logic      clear;
  line_idx_t clear_index;

  // Tag stage to data stage
  logic      tag_valid, tag_ready;
  addr_t     tag_addr;
  id_t       tag_id;
  logic      tag_hit, tag_error;
  set_idx_t  tag_set;

  tag_port_if tag_port ();

  icache_init_ctrl i_init_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_valid_i (flush_valid_i),
    .clear_o       (clear),
    .clear_index_o (clear_index)
  );

  icache_tag_stage i_tag_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear),
    .clear_index_i (clear_index),
    .in_addr_i     (in_addr_i),
    .in_id_i       (in_id_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .write_index_i (write_index_i),
    .write_set_i   (write_set_i),
    .write_tag_i   (write_tag_i),
    .write_error_i (write_error_i),
    .write_valid_i (write_valid_i),
    .write_ready_o (write_ready_o),
    .port          (tag_port.stage),
    .tag_valid_o   (tag_valid),
    .tag_addr_o    (tag_addr),
    .tag_id_o      (tag_id),
    .tag_hit_o     (tag_hit),
    .tag_set_o     (tag_set),
    .tag_error_o   (tag_error),
    .tag_ready_i   (tag_ready)
  );

  icache_tag_array i_tag_array (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .port   (tag_port.array)
  );

  icache_data_stage i_data_stage (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .clear_i       (clear),
    .tag_valid_i   (tag_valid),
    .tag_addr_i    (tag_addr),
    .tag_id_i      (tag_id),
    .tag_hit_i     (tag_hit),
    .tag_set_i     (tag_set),
    .tag_error_i   (tag_error),
    .tag_ready_o   (tag_ready),
    .write_index_i (write_index_i),
    .write_set_i   (write_set_i),
    .write_data_i  (write_data_i),
    .write_valid_i (write_valid_i),
    .out_addr_o    (out_addr_o),
    .out_id_o      (out_id_o),
    .out_set_o     (out_set_o),
    .out_hit_o     (out_hit_o),
    .out_error_o   (out_error_o),
    .out_data_o    (out_data_o),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i)
  );

endmodule

`default_nettype wire

// ==== hdl/icache_pkg.sv ====
/*
 * Instruction cache types
 * Address, tag and line types, tag entry layout and control enums
 */
`default_nettype none

`include "icache_cfg.svh"

package icache_pkg;

  typedef logic [`ICACHE_FETCH_AW-1:0]    addr_t;
  typedef logic [`ICACHE_ID_WIDTH-1:0]    id_t;
  typedef logic [`ICACHE_LINE_WIDTH-1:0]  line_t;
  typedef logic [`ICACHE_TAG_WIDTH-1:0]   tag_t;
  typedef logic [`ICACHE_COUNT_ALIGN-1:0] line_idx_t;
  typedef logic [`ICACHE_SET_ALIGN-1:0]   set_idx_t;

  // One tag slot, valid and error on top of the tag
  typedef struct packed {
    logic valid;
    logic error;
    tag_t tag;
  } tag_entry_t;

  // Owner of the shared tag port in a cycle
  typedef enum logic [1:0] {
    TAG_IDLE,
    TAG_CLEAR,
    TAG_REFILL,
    TAG_LOOKUP
  } tag_op_e;

  typedef enum logic {
    INIT_CLEAR,
    INIT_DONE
  } init_state_e;

endpackage

`default_nettype wire

// ==== hdl/icache_tag_array.sv ====
/*
 * Tag memory
 * One tag entry array per set behind a shared read/write port
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_tag_array import icache_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,
  tag_port_if.array  port
);

  tag_entry_t mem_q [`ICACHE_SET_COUNT][`ICACHE_LINE_COUNT];

  for (genvar s = 0; s < `ICACHE_SET_COUNT; s++) begin : g_set

    // Storage, every enabled set takes the same entry
    always_ff @(posedge clk_i) begin
      if (port.enable[s] && port.write) begin
        mem_q[s][port.index] <= port.wdata;
      end
    end

    // Read register, starts out as an invalid entry
    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        port.rdata[s] <= '0;
      end else if (port.enable[s] && !port.write) begin
        port.rdata[s] <= mem_q[s][port.index];
      end
    end

  end

endmodule

`default_nettype wire

// ==== hdl/icache_tag_stage.sv ====
/*
 * Tag stage
 * Owns the tag port, latches the lookup request and finds the hitting set
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

module icache_tag_stage import icache_pkg::*; (
  input  wire logic  clk_i,
  input  wire logic  rst_ni,

  input  wire logic  clear_i,
  input  line_idx_t  clear_index_i,

  input  addr_t      in_addr_i,
  input  id_t        in_id_i,
  input  wire logic  in_valid_i,
  output logic       in_ready_o,

  input  line_idx_t  write_index_i,
  input  set_idx_t   write_set_i,
  input  tag_t       write_tag_i,
  input  wire logic  write_error_i,
  input  wire logic  write_valid_i,
  output logic       write_ready_o,

  tag_port_if.stage  port,

  output logic       tag_valid_o,
  output addr_t      tag_addr_o,
  output id_t        tag_id_o,
  output logic       tag_hit_o,
  output set_idx_t   tag_set_o,
  output logic       tag_error_o,
  input  wire logic  tag_ready_i
);

  typedef struct packed {
    logic     hit;
    set_idx_t cset;
    logic     error;
  } tag_rsp_t;

  tag_op_e  op;
  logic     req_ready;
  logic     req_hs, req_hs_q;
  logic     tag_valid_q;
  addr_t    addr_q;
  id_t      id_q;
  tag_t     required_tag;
  tag_rsp_t rsp_s, rsp_q, rsp;

  // --------------------------------------------------
  // Port arbitration
  // --------------------------------------------------
  // Room in the register if empty or draining this cycle
  assign req_ready     = !tag_valid_q || tag_ready_i;
  assign write_ready_o = !clear_i;
  assign in_ready_o    = !clear_i && !write_valid_i && req_ready;

  always_comb begin
    if (clear_i) begin
      op = TAG_CLEAR;
    end else if (write_valid_i) begin
      op = TAG_REFILL;
    end else if (in_valid_i && req_ready) begin
      op = TAG_LOOKUP;
    end else begin
      op = TAG_IDLE;
    end
  end

  assign req_hs = (op == TAG_LOOKUP);

  always_comb begin
    port.enable = '0;
    port.write  = 1'b0;
    port.index  = in_addr_i[`ICACHE_LINE_ALIGN +: `ICACHE_COUNT_ALIGN];
    port.wdata  = '0;
    unique case (op)
      TAG_CLEAR: begin
        port.enable = '1;
        port.write  = 1'b1;
        port.index  = clear_index_i;
      end
      TAG_REFILL: begin
        port.enable[write_set_i] = 1'b1;
        port.write  = 1'b1;
        port.index  = write_index_i;
        port.wdata  = '{valid: 1'b1, error: write_error_i, tag: write_tag_i};
      end
      // Read every set at the lookup index
      TAG_LOOKUP: port.enable = '1;
      default: ;
    endcase
  end

  // --------------------------------------------------
  // Request register
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tag_valid_q <= 1'b0;
      req_hs_q    <= 1'b0;
    end else begin
      req_hs_q <= req_hs;
      if (req_hs) begin
        tag_valid_q <= 1'b1;
      end else if (tag_ready_i) begin
        tag_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_hs) begin
      addr_q <= in_addr_i;
      id_q   <= in_id_i;
    end
  end

  // --------------------------------------------------
  // Compare
  // --------------------------------------------------
  assign required_tag = addr_q[`ICACHE_FETCH_AW-1 -: `ICACHE_TAG_WIDTH];

  // Walk down so the lowest hitting set is the last one taken
  always_comb begin
    rsp_s = '0;
    for (int s = `ICACHE_SET_COUNT - 1; s >= 0; s--) begin
      if (port.rdata[s].valid && port.rdata[s].tag == required_tag) begin
        rsp_s.hit   = 1'b1;
        rsp_s.cset  = set_idx_t'(s);
        rsp_s.error = port.rdata[s].error;
      end
    end
  end

  // Fall-through buffer for a result the data stage cannot take yet
  always_ff @(posedge clk_i) begin
    if (req_hs_q && !tag_ready_i) begin
      rsp_q <= rsp_s;
    end
  end

  assign rsp = req_hs_q ? rsp_s : rsp_q;

  assign tag_valid_o = tag_valid_q;
  assign tag_addr_o  = addr_q;
  assign tag_id_o    = id_q;
  assign tag_hit_o   = rsp.hit;
  assign tag_set_o   = rsp.cset;
  assign tag_error_o = rsp.error;

  // Refills only arrive with the tag register empty so no compare sees a stale read
  a_no_refill_in_flight : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (write_valid_i && write_ready_o) |-> !tag_valid_q
  );

endmodule

`default_nettype wire

// ==== hdl/tag_port_if.sv ====
/*
 * Tag memory port
 * Single read/write port from the tag stage into the per-set tag memories
 */
`timescale 1ns/1ps
`default_nettype none

`include "icache_cfg.svh"

interface tag_port_if import icache_pkg::*; ();

  logic [`ICACHE_SET_COUNT-1:0] enable;
  logic                         write;
  line_idx_t                    index;
  tag_entry_t                   wdata;
  // Read data shows up one cycle after an enabled read
  tag_entry_t [`ICACHE_SET_COUNT-1:0] rdata;

  modport stage (
    output enable,
    output write,
    output index,
    output wdata,
    input  rdata
  );

  modport array (
    input  enable,
    input  write,
    input  index,
    input  wdata,
    output rdata
  );

endinterface

`default_nettype wire

// ==== include/icache_cfg.svh ====
/*
 * Instruction cache geometry
 * Address split, line size and set count for the lookup pipeline
 */
`ifndef ICACHE_CFG_SVH
`define ICACHE_CFG_SVH

// Fetch side
`define ICACHE_FETCH_AW    32
`define ICACHE_ID_WIDTH    4

// Cache shape
`define ICACHE_LINE_WIDTH  64
`define ICACHE_LINE_COUNT  16
`define ICACHE_SET_COUNT   2

// Address split: | tag | line index | byte offset |
`define ICACHE_LINE_ALIGN  3
`define ICACHE_COUNT_ALIGN 4
`define ICACHE_SET_ALIGN   1

// Whatever is left above the index is tag
`define ICACHE_TAG_WIDTH   (`ICACHE_FETCH_AW - `ICACHE_LINE_ALIGN - `ICACHE_COUNT_ALIGN)

`endif

// ==== sources.f ====
+incdir+include
hdl/icache_pkg.sv
hdl/tag_port_if.sv
hdl/icache_init_ctrl.sv
hdl/icache_tag_array.sv
hdl/icache_tag_stage.sv
hdl/icache_data_stage.sv
hdl/icache_lookup.sv
bench/tb_icache_lookup.sv
